// File: source/video_pkg.sv
package video_pkg;

    //////////////////////////////////////////////////
    // vector types

    // raster coordinate, x and y alike
    typedef logic [7:0]  coord_t;
    typedef logic [23:0] pixel_t;
    typedef logic [5:0]  fb_addr_t;
    typedef logic [1:0]  text_addr_t;
    typedef logic [7:0]  char_code_t;
    // character code in the upper bits, font row below
    typedef logic [9:0]  font_addr_t;
    // bit 7 is the leftmost pixel
    typedef logic [7:0]  font_row_t;

    typedef enum logic {
        RASTER_IDLE,
        RASTER_RUN
    } raster_state_t;

    //////////////////////////////////////////////////
    // raster timing of the test mode

    localparam coord_t H_TOTAL      = 8'd40;
    localparam coord_t H_VISIBLE    = 8'd32;
    localparam coord_t H_SYNC_START = 8'd34;
    localparam coord_t H_SYNC_WIDTH = 8'd3;

    localparam coord_t V_TOTAL      = 8'd24;
    localparam coord_t V_VISIBLE    = 8'd16;
    localparam coord_t V_SYNC_START = 8'd19;
    localparam coord_t V_SYNC_WIDTH = 8'd2;

    localparam logic SYNC_ON_POLARITY = 1'b1;

    // framebuffer geometry, 4x horizontal and 2x vertical
    localparam int PIXEL_REPEAT   = 4;
    localparam int LINE_REPEAT    = 2;
    localparam int FB_LINE_LENGTH = 8;

    //////////////////////////////////////////////////
    // on-screen display

    localparam coord_t OSD_BG_X_START   = 8'd4;
    localparam coord_t OSD_BG_X_END     = 8'd28;
    localparam coord_t OSD_BG_Y_START   = 8'd2;
    localparam coord_t OSD_BG_Y_END     = 8'd14;

    localparam coord_t OSD_TEXT_X_START = 8'd8;
    localparam coord_t OSD_TEXT_X_END   = 8'd24;
    localparam coord_t OSD_TEXT_Y_START = 8'd4;
    localparam coord_t OSD_TEXT_Y_END   = 8'd12;

    localparam int FONT_WIDTH   = 8;
    localparam int FONT_HEIGHT  = 4;
    localparam int TEXT_COLUMNS = 2;

    // cycles from raster coordinate to output pins
    localparam int OUTPUT_LATENCY = 4;

    localparam pixel_t OSD_TEXT_COLOR = 24'hffffff;

endpackage

// File: source/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    output video_pkg::coord_t x,
    output video_pkg::coord_t y,
    output logic              running,
    output logic              visible,
    output logic              hsync_raw,
    output logic              vsync_raw
);
    import video_pkg::*;

    raster_state_t state;
    coord_t        next_x;
    coord_t        next_y;
    logic          advance;

    // the start edge itself already loads coordinate 0,0
    assign advance = (state == RASTER_RUN) || start;
    assign running = (state == RASTER_RUN);

    //////////////////////////////////////////////////
    // next coordinate
    always_comb begin
        next_x = 8'd0;
        next_y = 8'd0;
        case (state)
            RASTER_IDLE: begin
                next_x = 8'd0;
                next_y = 8'd0;
            end
            RASTER_RUN: begin
                if (x == H_TOTAL - 8'd1) begin
                    next_x = 8'd0;
                    if (y == V_TOTAL - 8'd1) begin
                        next_y = 8'd0;
                    end else begin
                        next_y = y + 8'd1;
                    end
                end else begin
                    next_x = x + 8'd1;
                    next_y = y;
                end
            end
            default: begin
                next_x = 8'd0;
                next_y = 8'd0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // counters and raw flags, all for the same coordinate
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= RASTER_IDLE;
            x         <= 8'd0;
            y         <= 8'd0;
            visible   <= 1'b0;
            hsync_raw <= ~SYNC_ON_POLARITY;
            vsync_raw <= ~SYNC_ON_POLARITY;
        end else if (advance) begin
            state   <= RASTER_RUN;
            x       <= next_x;
            y       <= next_y;
            visible <= (next_x < H_VISIBLE) && (next_y < V_VISIBLE);

            if (next_x >= H_SYNC_START && next_x < H_SYNC_START + H_SYNC_WIDTH) begin
                hsync_raw <= SYNC_ON_POLARITY;
            end else begin
                hsync_raw <= ~SYNC_ON_POLARITY;
            end

            // whole lines only
            if (next_y >= V_SYNC_START && next_y < V_SYNC_START + V_SYNC_WIDTH) begin
                vsync_raw <= SYNC_ON_POLARITY;
            end else begin
                vsync_raw <= ~SYNC_ON_POLARITY;
            end
        end
    end

endmodule

// File: source/fb_fetch.sv
`timescale 1ns/1ps

module fb_fetch (
    input  logic                clock,
    input  logic                reset,
    input  video_pkg::coord_t   x,
    input  video_pkg::coord_t   y,
    input  logic                running,
    output video_pkg::fb_addr_t rdaddr
);
    import video_pkg::*;

    logic [1:0] rep_count;
    logic [2:0] column;
    logic       line_rep;
    fb_addr_t   line_base;
    logic       in_area;
    logic       line_end;

    assign in_area  = (x < H_VISIBLE) && (y < V_VISIBLE);
    assign line_end = (x == H_TOTAL - 8'd1);

    // column steps once every PIXEL_REPEAT visible pixels
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rep_count <= 2'd0;
            column    <= 3'd0;
        end else if (!running || line_end) begin
            rep_count <= 2'd0;
            column    <= 3'd0;
        end else if (x < H_VISIBLE) begin
            if (rep_count == 2'(PIXEL_REPEAT - 1)) begin
                rep_count <= 2'd0;
                column    <= column + 3'd1;
            end else begin
                rep_count <= rep_count + 2'd1;
            end
        end
    end

    // line doubling: LINE_REPEAT raster lines per buffer line
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_rep  <= 1'b0;
            line_base <= '0;
        end else if (!running) begin
            line_rep  <= 1'b0;
            line_base <= '0;
        end else if (line_end) begin
            if (y == V_TOTAL - 8'd1) begin
                line_rep  <= 1'b0;
                line_base <= '0;
            end else if (y < V_VISIBLE) begin
                if (line_rep == 1'(LINE_REPEAT - 1)) begin
                    line_rep  <= 1'b0;
                    line_base <= line_base + fb_addr_t'(FB_LINE_LENGTH);
                end else begin
                    line_rep <= line_rep + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rdaddr <= '0;
        end else begin
            rdaddr <= (running && in_area) ? line_base + fb_addr_t'(column) : '0;
        end
    end

endmodule

// File: source/osd_text.sv
`timescale 1ns/1ps

module osd_text (
    input  logic                  clock,
    input  logic                  reset,
    input  video_pkg::coord_t     x,
    input  video_pkg::coord_t     y,
    input  logic                  running,
    input  logic                  enable_osd,
    input  logic                  highlight_line,
    input  video_pkg::char_code_t text_rddata,
    input  video_pkg::font_row_t  char_rddata,
    output video_pkg::text_addr_t text_rdaddr,
    output video_pkg::font_addr_t char_rdaddr,
    output logic                  in_bg,
    output logic                  in_text,
    output logic                  font_bit
);
    import video_pkg::*;

    logic       bg_area;
    logic       text_area;
    coord_t     text_x;
    coord_t     text_y;
    logic       text_col;
    logic       text_row;
    logic [1:0] font_row;
    logic [2:0] font_col;

    logic       bg_s1;
    logic       text_s1;
    logic       row_s1;
    logic [1:0] font_row_s1;
    logic [2:0] font_col_s1;

    logic       bg_s2;
    logic       text_s2;
    logic       invert_s2;
    logic [2:0] font_col_s2;

    //////////////////////////////////////////////////
    // area tests and position inside the text box
    assign bg_area = running && enable_osd
                  && x >= OSD_BG_X_START && x < OSD_BG_X_END
                  && y >= OSD_BG_Y_START && y < OSD_BG_Y_END;
    assign text_area = running && enable_osd
                    && x >= OSD_TEXT_X_START && x < OSD_TEXT_X_END
                    && y >= OSD_TEXT_Y_START && y < OSD_TEXT_Y_END;

    assign text_x   = x - OSD_TEXT_X_START;
    assign text_y   = y - OSD_TEXT_Y_START;
    assign text_col = 1'(text_x / FONT_WIDTH);
    assign font_col = 3'(text_x % FONT_WIDTH);
    assign text_row = 1'(text_y / FONT_HEIGHT);
    assign font_row = 2'(text_y % FONT_HEIGHT);

    // stage 1: text memory address
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bg_s1       <= 1'b0;
            text_s1     <= 1'b0;
            text_rdaddr <= '0;
        end else begin
            bg_s1       <= bg_area;
            text_s1     <= text_area;
            text_rdaddr <= text_area ? text_addr_t'(text_row * TEXT_COLUMNS + text_col) : '0;
        end
    end

    always_ff @(posedge clock) begin
        row_s1      <= text_row;
        font_row_s1 <= font_row;
        font_col_s1 <= font_col;
    end

    // stage 2: character code is back, address the font
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bg_s2       <= 1'b0;
            text_s2     <= 1'b0;
            char_rdaddr <= '0;
        end else begin
            bg_s2       <= bg_s1;
            text_s2     <= text_s1;
            char_rdaddr <= {text_rddata, font_row_s1};
        end
    end

    always_ff @(posedge clock) begin
        invert_s2   <= (row_s1 == highlight_line);
        font_col_s2 <= font_col_s1;
    end

    // stage 3: pick the pixel, msb first
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_bg    <= 1'b0;
            in_text  <= 1'b0;
            font_bit <= 1'b0;
        end else begin
            in_bg    <= bg_s2;
            in_text  <= text_s2;
            font_bit <= char_rddata[3'(FONT_WIDTH - 1) - font_col_s2] ^ invert_s2;
        end
    end

endmodule

// File: source/pixel_output.sv
`timescale 1ns/1ps

module pixel_output (
    input  logic              clock,
    input  logic              reset,
    input  video_pkg::pixel_t rddata,
    input  logic              visible,
    input  logic              hsync_raw,
    input  logic              vsync_raw,
    input  logic              in_bg,
    input  logic              in_text,
    input  logic              font_bit,
    output video_pkg::pixel_t video_out,
    output logic              hsync,
    output logic              vsync,
    output logic              draw_area
);
    import video_pkg::*;

    // {visible, hsync, vsync} per delay stage
    logic [2:0][2:0] ctrl_pipe;
    logic            visible_d;
    logic            hsync_d;
    logic            vsync_d;

    pixel_t pixel_in;
    pixel_t pixel_d;
    pixel_t pixel_dim;

    assign visible_d = ctrl_pipe[2][2];
    assign hsync_d   = ctrl_pipe[2][1];
    assign vsync_d   = ctrl_pipe[2][0];

    // half brightness on every channel
    assign pixel_dim = (pixel_d >> 1) & 24'h7f7f7f;

    //////////////////////////////////////////////////
    // alignment to the osd flags
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ctrl_pipe <= {3{1'b0, ~SYNC_ON_POLARITY, ~SYNC_ON_POLARITY}};
        end else begin
            ctrl_pipe <= {ctrl_pipe[1:0], {visible, hsync_raw, vsync_raw}};
        end
    end

    // capture the read word, then one extra stage
    always_ff @(posedge clock) begin
        pixel_in <= rddata;
        pixel_d  <= pixel_in;
    end

    //////////////////////////////////////////////////
    // output register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            hsync     <= ~SYNC_ON_POLARITY;
            vsync     <= ~SYNC_ON_POLARITY;
            draw_area <= 1'b0;
        end else begin
            hsync     <= hsync_d;
            vsync     <= vsync_d;
            draw_area <= visible_d;

            if (!visible_d) begin
                video_out <= '0;
            end else if (in_text && font_bit) begin
                video_out <= OSD_TEXT_COLOR;
            end else if (in_bg) begin
                video_out <= pixel_dim;
            end else begin
                video_out <= pixel_d;
            end
        end
    end

endmodule

// File: source/video_scaler.sv
`timescale 1ns/1ps

module video_scaler (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  enable_osd,
    input  logic                  highlight_line,
    input  video_pkg::pixel_t     rddata,
    input  video_pkg::char_code_t text_rddata,
    input  video_pkg::font_row_t  char_rddata,
    output video_pkg::fb_addr_t   rdaddr,
    output video_pkg::text_addr_t text_rdaddr,
    output video_pkg::font_addr_t char_rdaddr,
    output video_pkg::pixel_t     video_out,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  draw_area
);
    import video_pkg::*;

    coord_t x;
    coord_t y;
    logic   running;
    logic   visible;
    logic   hsync_raw;
    logic   vsync_raw;

    logic   in_bg;
    logic   in_text;
    logic   font_bit;

    //////////////////////////////////////////////////
    // raster counters
    raster_timing timing (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .x         (x),
        .y         (y),
        .running   (running),
        .visible   (visible),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw)
    );

    // framebuffer address, 1 cycle
    fb_fetch fetch (
        .clock   (clock),
        .reset   (reset),
        .x       (x),
        .y       (y),
        .running (running),
        .rdaddr  (rdaddr)
    );

    // text box, 3 cycles through both memories
    osd_text osd (
        .clock          (clock),
        .reset          (reset),
        .x              (x),
        .y              (y),
        .running        (running),
        .enable_osd     (enable_osd),
        .highlight_line (highlight_line),
        .text_rddata    (text_rddata),
        .char_rddata    (char_rddata),
        .text_rdaddr    (text_rdaddr),
        .char_rdaddr    (char_rdaddr),
        .in_bg          (in_bg),
        .in_text        (in_text),
        .font_bit       (font_bit)
    );

    //////////////////////////////////////////////////
    // composition and sync alignment
    pixel_output out (
        .clock     (clock),
        .reset     (reset),
        .rddata    (rddata),
        .visible   (visible),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .in_bg     (in_bg),
        .in_text   (in_text),
        .font_bit  (font_bit),
        .video_out (video_out),
        .hsync     (hsync),
        .vsync     (vsync),
        .draw_area (draw_area)
    );

endmodule

// File: test/video_scaler_tb.sv
`timescale 1ns/1ps

module video_scaler_tb;
    import video_pkg::*;

    localparam int          CLOCK_PERIOD = 100;
    localparam int          FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int          WATCHDOG_NS  = (3 * FRAME_CYCLES + 200) * CLOCK_PERIOD;
    localparam logic [31:0] LCG_SEED     = 32'h010c59d9;

    logic       clock;
    logic       reset;
    logic       start;
    logic       enable_osd;
    logic       highlight_line;
    pixel_t     rddata;
    char_code_t text_rddata;
    font_row_t  char_rddata;
    fb_addr_t   rdaddr;
    text_addr_t text_rdaddr;
    font_addr_t char_rdaddr;
    pixel_t     video_out;
    logic       hsync;
    logic       vsync;
    logic       draw_area;

    int         errors;
    int         ref_count;
    int         out_index;
    int         out_x;
    int         out_y;
    int         fetch_index;
    int         fetch_x;
    int         fetch_y;
    int         char_index;
    int         char_x;
    int         char_y;
    logic       exp_hsync;
    logic       exp_vsync;
    logic       exp_draw;
    pixel_t     exp_video;
    fb_addr_t   exp_rdaddr;
    text_addr_t exp_text_addr;
    logic       char_check;
    font_addr_t exp_char_addr;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // framebuffer contents shift by this much per run
    localparam pixel_t FB_OFFSET = pixel_t'(lcg_next(LCG_SEED) >> 8);

    //////////////////////////////////////////////////
    // memory models
    function automatic pixel_t fb_word(input fb_addr_t addr);
        return pixel_t'({18'd0, addr} * 24'h010101) + FB_OFFSET;
    endfunction

    function automatic font_row_t font_bits(input char_code_t code, input logic [1:0] row);
        logic [15:0] product;
        product = {8'd0, code} * 16'd7 + {14'd0, row};
        return product[7:0];
    endfunction

    assign rddata      = fb_word(rdaddr);
    assign text_rddata = {6'd0, text_rdaddr} + 8'h41;
    assign char_rddata = font_bits(char_rdaddr[9:2], char_rdaddr[1:0]);

    //////////////////////////////////////////////////
    // reference model
    function automatic pixel_t halve(input pixel_t p);
        return {1'b0, p[23:17], 1'b0, p[15:9], 1'b0, p[7:1]};
    endfunction

    function automatic logic in_rect(input int px, input int py,
                                     input coord_t x0, input coord_t x1,
                                     input coord_t y0, input coord_t y1);
        return px >= int'(x0) && px < int'(x1) && py >= int'(y0) && py < int'(y1);
    endfunction

    function automatic pixel_t expected_video(input int px, input int py,
                                              input logic osd, input logic hl);
        int        tx;
        int        ty;
        int        row;
        font_row_t bits;
        logic      lit;
        pixel_t    base;
        if (!in_rect(px, py, 8'd0, H_VISIBLE, 8'd0, V_VISIBLE)) begin
            return '0;
        end
        base = fb_word(fb_addr_t'((py / LINE_REPEAT) * FB_LINE_LENGTH + px / PIXEL_REPEAT));
        if (!osd) begin
            return base;
        end
        if (in_rect(px, py, OSD_TEXT_X_START, OSD_TEXT_X_END,
                    OSD_TEXT_Y_START, OSD_TEXT_Y_END)) begin
            tx   = px - int'(OSD_TEXT_X_START);
            ty   = py - int'(OSD_TEXT_Y_START);
            row  = ty / FONT_HEIGHT;
            bits = font_bits(char_code_t'(row * TEXT_COLUMNS + tx / FONT_WIDTH) + 8'h41,
                             2'(ty % FONT_HEIGHT));
            // highlighted row shows inverted glyphs
            lit  = bits[3'(7 - tx % FONT_WIDTH)] ^ (row == int'(hl));
            return lit ? OSD_TEXT_COLOR : halve(base);
        end
        if (in_rect(px, py, OSD_BG_X_START, OSD_BG_X_END, OSD_BG_Y_START, OSD_BG_Y_END)) begin
            return halve(base);
        end
        return base;
    endfunction

    // cycles since the start edge, -1 while idle
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            ref_count <= -1;
        end else if (ref_count >= 0 || start) begin
            ref_count <= ref_count + 1;
        end
    end

    always_comb begin
        out_index     = ref_count - OUTPUT_LATENCY;
        out_x         = out_index % int'(H_TOTAL);
        out_y         = (out_index / int'(H_TOTAL)) % int'(V_TOTAL);
        fetch_index   = ref_count - 1;
        fetch_x       = fetch_index % int'(H_TOTAL);
        fetch_y       = (fetch_index / int'(H_TOTAL)) % int'(V_TOTAL);
        char_index    = ref_count - 2;
        char_x        = char_index % int'(H_TOTAL);
        char_y        = (char_index / int'(H_TOTAL)) % int'(V_TOTAL);
        exp_hsync     = out_index >= 0 && in_rect(out_x, out_y, H_SYNC_START,
                                                  H_SYNC_START + H_SYNC_WIDTH, 8'd0, V_TOTAL);
        exp_vsync     = out_index >= 0 && in_rect(out_x, out_y, 8'd0, H_TOTAL,
                                                  V_SYNC_START, V_SYNC_START + V_SYNC_WIDTH);
        exp_draw      = out_index >= 0 && in_rect(out_x, out_y, 8'd0, H_VISIBLE, 8'd0, V_VISIBLE);
        exp_video     = (out_index >= 0) ? expected_video(out_x, out_y, enable_osd, highlight_line)
                                         : '0;
        exp_rdaddr    = '0;
        exp_text_addr = '0;
        if (fetch_index >= 0 && in_rect(fetch_x, fetch_y, 8'd0, H_VISIBLE, 8'd0, V_VISIBLE)) begin
            exp_rdaddr = fb_addr_t'((fetch_y / LINE_REPEAT) * FB_LINE_LENGTH
                                    + fetch_x / PIXEL_REPEAT);
        end
        if (fetch_index >= 0 && enable_osd && in_rect(fetch_x, fetch_y, OSD_TEXT_X_START,
                OSD_TEXT_X_END, OSD_TEXT_Y_START, OSD_TEXT_Y_END)) begin
            exp_text_addr = text_addr_t'(((fetch_y - 4) / FONT_HEIGHT) * TEXT_COLUMNS
                                         + (fetch_x - 8) / FONT_WIDTH);
        end
        // font address: character code of the cell, then the row inside the glyph
        char_check    = char_index >= 0 && enable_osd && in_rect(char_x, char_y,
                            OSD_TEXT_X_START, OSD_TEXT_X_END, OSD_TEXT_Y_START, OSD_TEXT_Y_END);
        exp_char_addr = {char_code_t'((char_y - int'(OSD_TEXT_Y_START)) / FONT_HEIGHT
                                      * TEXT_COLUMNS
                                      + (char_x - int'(OSD_TEXT_X_START)) / FONT_WIDTH)
                         + 8'h41,
                         2'((char_y - int'(OSD_TEXT_Y_START)) % FONT_HEIGHT)};
    end

    //////////////////////////////////////////////////
    // checks
    idle_outputs: assert property (@(posedge clock) disable iff (reset)
        ref_count < OUTPUT_LATENCY |-> !hsync && !vsync && !draw_area && video_out == '0)
    else begin
        errors++;
        $display("Error at %0t: outputs active before the pipeline filled", $time);
    end

    sync_timing: assert property (@(posedge clock) disable iff (reset)
        hsync == exp_hsync && vsync == exp_vsync)
    else begin
        errors++;
        $display("Error at %0t: hsync %b vsync %b, expected %b %b", $time,
                 $sampled(hsync), $sampled(vsync), $sampled(exp_hsync), $sampled(exp_vsync));
    end

    draw_flag: assert property (@(posedge clock) disable iff (reset) draw_area == exp_draw)
    else begin
        errors++;
        $display("Error at %0t: draw_area %b, expected %b", $time,
                 $sampled(draw_area), $sampled(exp_draw));
    end

    video_value: assert property (@(posedge clock) disable iff (reset) video_out == exp_video)
    else begin
        errors++;
        $display("Error at %0t: video_out %h, expected %h", $time,
                 $sampled(video_out), $sampled(exp_video));
    end

    fb_address: assert property (@(posedge clock) disable iff (reset) rdaddr == exp_rdaddr)
    else begin
        errors++;
        $display("Error at %0t: rdaddr %0d, expected %0d", $time,
                 $sampled(rdaddr), $sampled(exp_rdaddr));
    end

    text_address: assert property (@(posedge clock) disable iff (reset)
        text_rdaddr == exp_text_addr)
    else begin
        errors++;
        $display("Error at %0t: text_rdaddr %0d, expected %0d", $time,
                 $sampled(text_rdaddr), $sampled(exp_text_addr));
    end

    char_address: assert property (@(posedge clock) disable iff (reset)
        char_check |-> char_rdaddr == exp_char_addr)
    else begin
        errors++;
        $display("Error at %0t: char_rdaddr %h, expected %h", $time,
                 $sampled(char_rdaddr), $sampled(exp_char_addr));
    end

    //////////////////////////////////////////////////
    // stimulus
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    video_scaler uut (
        .clock(clock), .reset(reset), .start(start), .enable_osd(enable_osd),
        .highlight_line(highlight_line), .rddata(rddata), .text_rddata(text_rddata),
        .char_rddata(char_rddata), .rdaddr(rdaddr), .text_rdaddr(text_rdaddr),
        .char_rdaddr(char_rdaddr), .video_out(video_out), .hsync(hsync),
        .vsync(vsync), .draw_area(draw_area)
    );

    initial begin
        errors         = 0;
        clock          = 1'b0;
        reset          = 1'b1;
        start          = 1'b0;
        enable_osd     = 1'b0;
        highlight_line = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        // idle cycles before the raster starts
        repeat (3) @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;

        // frame 0 plain, frame 1 with text box, frame 2 with row 1 highlighted
        @(posedge vsync);
        @(posedge clock);
        enable_osd <= 1'b1;
        @(posedge vsync);
        @(posedge clock);
        highlight_line <= 1'b1;
        @(posedge vsync);
        repeat (4) @(posedge clock);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: the raster did not complete three frames in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: all.f
source/video_pkg.sv
source/raster_timing.sv
source/fb_fetch.sv
source/osd_text.sv
source/pixel_output.sv
source/video_scaler.sv
test/video_scaler_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module video_scaler_tb \
    -f all.f -o video_scaler_sim \
    && ./obj_dir/video_scaler_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
